// ==== filelist.f ====
+incdir+.
lsu_access_pkg.sv
lsu_bus_pkg.sv
lsu_store_align.sv
lsu_load_align.sv
lsu_obi_port.sv
lsu_top.sv
tb_lsu.sv

// ==== Makefile ====
# Verilator simulation of the load/store unit

VERILATOR ?= verilator
TOP       ?= tb_lsu
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= Done: no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== tb_lsu.sv ====
// Testbench of the load/store unit
// Clock, reset, bus memory model, EX driver, reference model, checker, watchdog
`timescale 1ns/10ps
`include "lsu_config.svh"

module tb_lsu;

  import lsu_access_pkg::*;
  import lsu_bus_pkg::*;

  // Accesses per test to size the watchdog
  localparam int ACC_T1 = 8;
  localparam int ACC_T2 = 9;
  localparam int ACC_T3 = 28;
  localparam int ACC_T4 = 5;
  localparam int ACC_T5 = 9;
  localparam int ACC_T6 = 8;
  localparam int ACC_ALL = ACC_T1 + ACC_T2 + ACC_T3 + ACC_T4 + ACC_T5 + ACC_T6;

  logic       clk;
  logic       rst_n;
  logic       data_req_ex;
  logic       data_we_ex;
  data_size_e data_size_ex;
  ext_mode_e  data_ext_mode_ex;
  word_t      data_wdata_ex;
  logic [1:0] data_reg_offset_ex;
  addr_t      operand_a_ex;
  addr_t      operand_b_ex;
  logic       addr_useincr_ex;
  logic       data_misaligned_ex;
  word_t      data_rdata_ex;
  logic       data_misaligned;
  logic       lsu_ready_ex;
  logic       lsu_ready_wb;
  logic       busy;
  logic       data_req;
  addr_t      data_addr;
  logic       data_we;
  be_t        data_be;
  word_t      data_wdata;
  logic       data_gnt;
  logic       data_rvalid;
  word_t      data_rdata;

  lsu_top lsu_top_inst (
    .clk (clk), .rst_n (rst_n),
    .data_req_ex_i (data_req_ex), .data_we_ex_i (data_we_ex),
    .data_size_ex_i (data_size_ex), .data_ext_mode_ex_i (data_ext_mode_ex),
    .data_wdata_ex_i (data_wdata_ex), .data_reg_offset_ex_i (data_reg_offset_ex),
    .operand_a_ex_i (operand_a_ex), .operand_b_ex_i (operand_b_ex),
    .addr_useincr_ex_i (addr_useincr_ex), .data_misaligned_ex_i (data_misaligned_ex),
    .data_rdata_ex_o (data_rdata_ex), .data_misaligned_o (data_misaligned),
    .lsu_ready_ex_o (lsu_ready_ex), .lsu_ready_wb_o (lsu_ready_wb), .busy_o (busy),
    .data_req_o (data_req), .data_addr_o (data_addr), .data_we_o (data_we),
    .data_be_o (data_be), .data_wdata_o (data_wdata),
    .data_gnt_i (data_gnt), .data_rvalid_i (data_rvalid), .data_rdata_i (data_rdata)
  );

  integer      seed = 12;
  integer      errors = 0;
  integer      tests = 0;
  integer      failed = 0;
  integer      test_err0;
  string       cur_test;
  logic [31:0] mem [0:255];     // Bus side memory
  logic [7:0]  shadow [0:1023]; // Byte copy kept by the EX driver
  bit          gnt_hold = 1'b0; // Withhold the grant
  bit          slow_resp = 1'b0;
  // One expected response per bus transaction
  bit          exp_final[$];
  logic [31:0] exp_val[$];
  string       exp_name[$];

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] fill_word(input integer idx);
    return (idx + 1) * 32'h9E37_79B1 ^ (idx << 12);  // Differs per word index
  endfunction

  //////////////////////////////////////////////////
  // Reference model
  function automatic logic [31:0] ref_load(input logic [31:0] addr, input logic [1:0] size,
                                           input logic [1:0] ext);
    logic [31:0] raw;
    integer      n;
    integer      j;
    logic        fill;
    n   = (size == 2'b00) ? 4 : ((size == 2'b01) ? 2 : 1);
    raw = 32'h0;
    for (j = 0; j < n; j++) raw[8*j +: 8] = shadow[(addr + j) & 32'h3FF];
    fill = (ext == 2'b00) ? 1'b0 : ((ext == 2'b10) ? 1'b1 : raw[8*n-1]);  // 11 as sign
    for (j = 8 * n; j < 32; j++) raw[j] = fill;
    return raw;
  endfunction

  // Lanes covered by one part of the access
  function automatic logic [3:0] expected_be(input integer n, input integer lsb, input bit second);
    logic [3:0] be;
    integer     l;
    integer     pos;
    be = 4'b0000;
    for (l = 0; l < 4; l++) begin
      pos = second ? l + 4 : l;
      if (pos >= lsb && pos < lsb + n) be[l] = 1'b1;
    end
    return be;
  endfunction

  // Register byte roff lands on lane lsb
  function automatic logic [31:0] expected_wdata(input logic [31:0] w, input logic [1:0] lsb,
                                                 input logic [1:0] roff);
    logic [31:0] r;
    integer      l;
    logic [1:0]  src;
    for (l = 0; l < 4; l++) begin
      src = 2'(l) - lsb + roff;
      r[8*l +: 8] = w[8*src +: 8];
    end
    return r;
  endfunction

  task automatic report_mismatch(input string what, input logic [31:0] exp, input logic [31:0] act);
    errors++;
    $display("[ERROR] %s %s: expected %h actual %h", cur_test, what, exp, act);
  endtask

  //////////////////////////////////////////////////
  // Memory model and bus monitors
  integer      edge_cnt = 0;
  integer      last_due = 0;
  integer      outstanding = 0;
  integer      gnt_wait = 0;
  integer      due;
  integer      l;
  logic [7:0]  widx;
  logic [31:0] rq_data[$];
  integer      rq_due[$];
  bit          prev_pend = 1'b0;
  logic [67:0] prev_phase;
  bit          req_exp;

  always @(posedge clk) begin
    if (rst_n) begin
      req_exp = data_req_ex && (outstanding < `LSU_DEPTH);  // Offered only below the depth
      if (data_req !== req_exp)
        report_mismatch("request", {31'h0, req_exp}, {31'h0, data_req});
      if (busy !== ((outstanding != 0) || req_exp))
        report_mismatch("busy", {31'h0, (outstanding != 0) || req_exp}, {31'h0, busy});
      if (lsu_ready_wb !== ((outstanding == 0) || data_rvalid))
        report_mismatch("WB ready", {31'h0, (outstanding == 0) || data_rvalid},
                        {31'h0, lsu_ready_wb});
      if (req_exp && !data_gnt && lsu_ready_ex) begin
        errors++;
        $display("[ERROR] %s: EX ready while the grant was withheld", cur_test);
      end
      if (prev_pend && (!data_req || prev_phase !== {data_addr, data_be, data_wdata})) begin
        errors++;
        $display("[ERROR] %s: address phase changed while the grant was withheld", cur_test);
      end
      prev_pend  = data_req && !data_gnt;
      prev_phase = {data_addr, data_be, data_wdata};
      if (data_req && data_gnt) begin
        widx = data_addr[9:2];
        if (data_we) begin
          for (l = 0; l < 4; l++) if (data_be[l]) mem[widx][8*l +: 8] = data_wdata[8*l +: 8];
        end
        rq_data.push_back(mem[widx]);
        due = edge_cnt + ({$random(seed)} % 3) + (slow_resp ? 3 : 0);
        if (due <= last_due) due = last_due + 1;  // In order
        last_due = due;
        rq_due.push_back(due);
        outstanding++;
      end
      if (data_rvalid) outstanding--;
      if (outstanding > `LSU_DEPTH) begin
        errors++;
        $display("[ERROR] %s: %0d transactions outstanding", cur_test, outstanding);
      end
    end
    data_rvalid <= 1'b0;
    if (rq_due.size() != 0 && rq_due[0] <= edge_cnt) begin
      data_rvalid <= 1'b1;
      data_rdata  <= rq_data.pop_front();
      due = rq_due.pop_front();
    end
    gnt_wait = (data_req && !data_gnt) ? gnt_wait + 1 : 0;
    data_gnt <= !gnt_hold && ((gnt_wait >= 2) || $random(seed) & 1);
    edge_cnt++;
  end

  // Checker of final load responses against the reference
  always @(posedge clk) begin
    if (rst_n && data_rvalid) begin
      if (exp_final.size() == 0) begin
        errors++;
        $display("[ERROR] %s: response without a pending transaction", cur_test);
      end else begin
        if (exp_final[0] && data_rdata_ex !== exp_val[0])
          report_mismatch(exp_name[0], exp_val[0], data_rdata_ex);
        exp_final.delete(0);
        exp_val.delete(0);
        exp_name.delete(0);
      end
    end
  end

  //////////////////////////////////////////////////
  // EX stage driver
  task automatic issue_part(input bit we, input logic [1:0] size, input logic [1:0] ext,
                            input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [1:0] roff, input bit mis, input bit second);
    logic [31:0] opb;
    logic [31:0] exp_addr;
    integer      n;
    n   = (size == 2'b00) ? 4 : ((size == 2'b01) ? 2 : 1);
    opb = addr[3] ? 32'h10 : 32'h0;  // Half the accesses use a + b
    data_req_ex        <= 1'b1;
    data_we_ex         <= we;
    data_size_ex       <= data_size_e'(size);
    data_ext_mode_ex   <= ext_mode_e'(ext);
    data_wdata_ex      <= wdata;
    data_reg_offset_ex <= roff;
    operand_a_ex       <= (second ? addr + 32'd4 : addr) - opb;
    operand_b_ex       <= opb;
    addr_useincr_ex    <= addr[3];
    data_misaligned_ex <= second;
    @(posedge clk);
    while (!lsu_ready_ex) @(posedge clk);
    exp_addr = second ? ((addr + 32'd4) & 32'hFFFF_FFFC) : addr;
    if (data_addr !== exp_addr) report_mismatch("address", exp_addr, data_addr);
    if (data_we !== we) report_mismatch("write enable", {31'h0, we}, {31'h0, data_we});
    if (data_be !== expected_be(n, addr[1:0], second))
      report_mismatch("byte enable", {28'h0, expected_be(n, addr[1:0], second)}, {28'h0, data_be});
    if (we && data_wdata !== expected_wdata(wdata, addr[1:0], roff))
      report_mismatch("write data", expected_wdata(wdata, addr[1:0], roff), data_wdata);
    if (!second && data_misaligned !== mis)
      report_mismatch("misaligned flag", {31'h0, mis}, {31'h0, data_misaligned});
  endtask

  task automatic access(input bit we, input logic [1:0] size, input logic [1:0] ext,
                        input logic [31:0] addr, input logic [31:0] wdata, input logic [1:0] roff);
    integer      n;
    integer      j;
    bit          mis;
    logic [31:0] expv;
    n    = (size == 2'b00) ? 4 : ((size == 2'b01) ? 2 : 1);
    mis  = (n == 4 && addr[1:0] != 2'b00) || (n == 2 && addr[1:0] == 2'b11);
    expv = 32'h0;
    if (we) begin
      for (j = 0; j < n; j++) shadow[(addr + j) & 32'h3FF] = wdata[8*((roff + j) % 4) +: 8];
    end else begin
      expv = ref_load(addr, size, ext);
    end
    issue_part(we, size, ext, addr, wdata, roff, mis, 1'b0);
    exp_final.push_back(!we && !mis);
    exp_val.push_back(expv);
    exp_name.push_back($sformatf("load %h", addr));
    if (mis) begin  // Second part at the next word
      issue_part(we, size, ext, addr, wdata, roff, mis, 1'b1);
      exp_final.push_back(!we);
      exp_val.push_back(expv);
      exp_name.push_back($sformatf("load %h", addr));
    end
  endtask

  task automatic begin_test(input string name);
    cur_test  = name;
    test_err0 = errors;
  endtask

  task automatic end_test;
    data_req_ex        <= 1'b0;
    data_misaligned_ex <= 1'b0;
    while (exp_final.size() != 0) @(posedge clk);  // Drain responses
    @(posedge clk);
    tests++;
    if (errors != test_err0) failed++;
    $display("%s: %s, %0d errors", cur_test, (errors == test_err0) ? "ok" : "FAILED",
             errors - test_err0);
  endtask

  // Watchdog
  initial begin
    repeat (16 + 200 * ACC_ALL) @(posedge clk);
    $display("Timeout: the tests did not finish in %0d cycles", 16 + 200 * ACC_ALL);
    $display("Done: errors found");
    $finish;
  end

  integer i;
  integer k;

  initial begin
    for (i = 0; i < 256; i++) begin
      mem[i] = fill_word(i);
      for (k = 0; k < 4; k++) shadow[4*i + k] = mem[i][8*k +: 8];
    end
    rst_n = 1'b0;
    data_req_ex = 1'b0;
    data_we_ex = 1'b0;
    data_size_ex = SIZE_WORD;
    data_ext_mode_ex = EXT_ZERO;
    data_wdata_ex = 32'h0;
    data_reg_offset_ex = 2'b00;
    operand_a_ex = 32'h0;
    operand_b_ex = 32'h0;
    addr_useincr_ex = 1'b0;
    data_misaligned_ex = 1'b0;
    data_gnt = 1'b0;
    data_rvalid = 1'b0;
    data_rdata = 32'h0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    begin_test("aligned words");
    for (i = 0; i < 4; i++) access(1'b1, 2'b00, 2'b00, 32'h100 + 4 * i, $random(seed), 2'b00);
    for (i = 0; i < 4; i++) access(1'b0, 2'b00, 2'b00, 32'h100 + 4 * i, 32'h0, 2'b00);
    end_test();

    begin_test("byte and half stores");
    for (i = 0; i < 4; i++) access(1'b1, 2'b10, 2'b00, 32'h140 + i, $random(seed), 2'(i + 1));
    access(1'b0, 2'b00, 2'b00, 32'h140, 32'h0, 2'b00);
    for (i = 0; i < 3; i++) access(1'b1, 2'b01, 2'b00, 32'h150 + i, $random(seed), 2'(i ^ 2));
    access(1'b0, 2'b00, 2'b00, 32'h150, 32'h0, 2'b00);
    end_test();

    begin_test("byte and half loads");
    for (k = 0; k < 4; k++) begin  // All extension modes
      for (i = 0; i < 4; i++) access(1'b0, 2'b11 - 2'(k & 1), 2'(k), 32'h188 + i, 32'h0, 2'b00);
      for (i = 0; i < 3; i++) access(1'b0, 2'b01, 2'(k), 32'h184 + i, 32'h0, 2'b00);
    end
    end_test();

    begin_test("misaligned loads");
    for (i = 1; i < 4; i++) access(1'b0, 2'b00, 2'b00, 32'h1C0 + 4 * i + i, 32'h0, 2'b00);
    access(1'b0, 2'b01, 2'b01, 32'h1E3, 32'h0, 2'b00);
    access(1'b0, 2'b01, 2'b10, 32'h1EB, 32'h0, 2'b00);
    end_test();

    begin_test("misaligned stores");
    for (i = 1; i < 4; i++) begin
      access(1'b1, 2'b00, 2'b00, 32'h200 + 8 * i + i, $random(seed), 2'b00);
      access(1'b0, 2'b00, 2'b00, 32'h200 + 8 * i, 32'h0, 2'b00);
      access(1'b0, 2'b00, 2'b00, 32'h204 + 8 * i, 32'h0, 2'b00);
    end
    end_test();

    begin_test("burst under back-pressure");
    gnt_hold  <= 1'b1;
    slow_resp <= 1'b1;
    fork
      begin
        for (i = 0; i < 8; i++) access(1'b0, (i % 2 == 0) ? 2'b00 : 2'b01, 2'b01,
                                       32'h100 + 4 * i + 2 * (i % 2), 32'h0, 2'b00);
      end
      begin
        repeat (6) @(posedge clk);
        gnt_hold <= 1'b0;
      end
    join
    end_test();
    slow_resp <= 1'b0;
    if (busy !== 1'b0) begin
      errors++;
      $display("[ERROR] busy stays high after all responses returned");
    end

    $display("tests=%0d failed=%0d errors=%0d", tests, failed, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== lsu_top.sv ====
// Load/store unit top level
// Address formatting, data bus port and load alignment
`timescale 1ns/10ps

module lsu_top (
  input  logic                       clk,
  input  logic                       rst_n,
  // EX stage
  input  logic                       data_req_ex_i,
  input  logic                       data_we_ex_i,
  input  lsu_access_pkg::data_size_e data_size_ex_i,
  input  lsu_access_pkg::ext_mode_e  data_ext_mode_ex_i,
  input  lsu_bus_pkg::word_t         data_wdata_ex_i,
  input  logic [1:0]                 data_reg_offset_ex_i,
  input  lsu_bus_pkg::addr_t         operand_a_ex_i,
  input  lsu_bus_pkg::addr_t         operand_b_ex_i,
  input  logic                       addr_useincr_ex_i,
  input  logic                       data_misaligned_ex_i,  // Second part from the controller
  output lsu_bus_pkg::word_t         data_rdata_ex_o,
  output logic                       data_misaligned_o,     // Split access to the controller
  output logic                       lsu_ready_ex_o,
  output logic                       lsu_ready_wb_o,
  output logic                       busy_o,
  // Data bus
  output logic                       data_req_o,
  output lsu_bus_pkg::addr_t         data_addr_o,
  output logic                       data_we_o,
  output lsu_bus_pkg::be_t           data_be_o,
  output lsu_bus_pkg::word_t         data_wdata_o,
  input  logic                       data_gnt_i,
  input  logic                       data_rvalid_i,
  input  lsu_bus_pkg::word_t         data_rdata_i
);

  import lsu_bus_pkg::*;

  addr_t      trans_addr;
  be_t        trans_be;
  word_t      trans_wdata;
  logic [1:0] addr_lsb;
  logic       ctrl_update;
  logic       resp_valid;

  lsu_store_align store_align_inst (
    .operand_a_i     (operand_a_ex_i),
    .operand_b_i     (operand_b_ex_i),
    .addr_useincr_i  (addr_useincr_ex_i),
    .data_size_i     (data_size_ex_i),
    .data_wdata_i    (data_wdata_ex_i),
    .reg_offset_i    (data_reg_offset_ex_i),
    .data_req_i      (data_req_ex_i),
    .misaligned_ex_i (data_misaligned_ex_i),
    .trans_addr_o    (trans_addr),
    .addr_lsb_o      (addr_lsb),
    .trans_be_o      (trans_be),
    .trans_wdata_o   (trans_wdata),
    .misaligned_o    (data_misaligned_o)
  );

  lsu_obi_port obi_port_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .data_req_ex_i  (data_req_ex_i),
    .data_we_ex_i   (data_we_ex_i),
    .trans_addr_i   (trans_addr),
    .trans_be_i     (trans_be),
    .trans_wdata_i  (trans_wdata),
    .data_gnt_i     (data_gnt_i),
    .data_rvalid_i  (data_rvalid_i),
    .data_req_o     (data_req_o),
    .data_addr_o    (data_addr_o),
    .data_we_o      (data_we_o),
    .data_be_o      (data_be_o),
    .data_wdata_o   (data_wdata_o),
    .resp_valid_o   (resp_valid),
    .ctrl_update_o  (ctrl_update),
    .lsu_ready_ex_o (lsu_ready_ex_o),
    .lsu_ready_wb_o (lsu_ready_wb_o),
    .busy_o         (busy_o)
  );

  lsu_load_align load_align_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .ctrl_update_i   (ctrl_update),
    .data_size_i     (data_size_ex_i),
    .ext_mode_i      (data_ext_mode_ex_i),
    .data_we_i       (data_we_ex_i),
    .addr_lsb_i      (addr_lsb),
    .resp_valid_i    (resp_valid),
    .resp_rdata_i    (data_rdata_i),
    .misaligned_ex_i (data_misaligned_ex_i),
    .misaligned_i    (data_misaligned_o),
    .rdata_ex_o      (data_rdata_ex_o)
  );

endmodule

// ==== lsu_obi_port.sv ====
// Data bus port of the load/store unit
// Outstanding counter, request drive, EX and WB ready, busy
`timescale 1ns/10ps
`include "lsu_config.svh"

module lsu_obi_port (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               data_req_ex_i,
  input  logic               data_we_ex_i,
  input  lsu_bus_pkg::addr_t trans_addr_i,
  input  lsu_bus_pkg::be_t   trans_be_i,
  input  lsu_bus_pkg::word_t trans_wdata_i,
  input  logic               data_gnt_i,
  input  logic               data_rvalid_i,
  output logic               data_req_o,
  output lsu_bus_pkg::addr_t data_addr_o,
  output logic               data_we_o,
  output lsu_bus_pkg::be_t   data_be_o,
  output lsu_bus_pkg::word_t data_wdata_o,
  output logic               resp_valid_o,
  output logic               ctrl_update_o,   // EX access moves into WB
  output logic               lsu_ready_ex_o,
  output logic               lsu_ready_wb_o,
  output logic               busy_o
);

  import lsu_bus_pkg::*;

  out_cnt_t cnt_q;       // Outstanding transactions
  out_cnt_t cnt_d;
  logic     trans_valid;
  logic     count_up;    // Grant this cycle
  logic     count_down;  // Response this cycle

  // No path from rvalid to the request
  assign trans_valid  = data_req_ex_i && (cnt_q < `LSU_DEPTH);

  assign data_req_o   = trans_valid;
  assign data_addr_o  = trans_addr_i;   // Held by EX until ready
  assign data_we_o    = data_we_ex_i;
  assign data_be_o    = trans_be_i;
  assign data_wdata_o = trans_wdata_i;
  assign resp_valid_o = data_rvalid_i;

  assign count_up   = trans_valid && data_gnt_i;
  assign count_down = data_rvalid_i;

  //////////////////////////////////////////////////
  // Outstanding counter
  always_comb begin
    case ({count_up, count_down})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      default: cnt_d = cnt_q;  // Idle, or one in and one out
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // EX and WB advance together once WB is in use
  assign lsu_ready_ex_o = !data_req_ex_i                 ? 1'b1 :
                          (cnt_q == out_cnt_t'(0))       ? count_up :
                          (cnt_q == out_cnt_t'(1))       ? (count_up && data_rvalid_i) :
                                                           data_rvalid_i;
  assign lsu_ready_wb_o = (cnt_q == out_cnt_t'(0)) ? 1'b1 : data_rvalid_i;
  assign ctrl_update_o  = lsu_ready_ex_o && data_req_ex_i;
  assign busy_o         = (cnt_q != out_cnt_t'(0)) || trans_valid;

  //////////////////////////////////////////////////
  // Bus checks
  a_cnt_in_range : assert property (
    @(posedge clk) disable iff (!rst_n) cnt_q <= `LSU_DEPTH
  );

  a_no_spurious_rvalid : assert property (
    @(posedge clk) disable iff (!rst_n) data_rvalid_i |-> (cnt_q != out_cnt_t'(0))
  );

  a_addr_phase_known : assert property (
    @(posedge clk) disable iff (!rst_n)
    data_req_o |-> !$isunknown({data_addr_o, data_we_o, data_be_o})
  );

endmodule

// ==== lsu_load_align.sv ====
// WB side of the load path
// Control registers, held read word, misaligned assembly, extension
`timescale 1ns/10ps
`include "lsu_config.svh"

module lsu_load_align (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       ctrl_update_i,    // Access moves from EX into WB
  input  lsu_access_pkg::data_size_e data_size_i,
  input  lsu_access_pkg::ext_mode_e  ext_mode_i,
  input  logic                       data_we_i,
  input  logic [1:0]                 addr_lsb_i,
  input  logic                       resp_valid_i,
  input  lsu_bus_pkg::word_t         resp_rdata_i,
  input  logic                       misaligned_ex_i,  // Second part waits in EX
  input  logic                       misaligned_i,     // Split detected on the EX access
  output lsu_bus_pkg::word_t         rdata_ex_o
);

  import lsu_access_pkg::*;
  import lsu_bus_pkg::*;

  // WB copy of the access
  data_size_e size_q;
  ext_mode_e  ext_q;
  logic [1:0] offset_q;
  logic       we_q;

  load_word_u  resp_w;
  load_word_u  hold_q;     // Raw first part, or last result
  word_t       word_asm;   // Word, assembled when split
  logic [15:0] half_sel;
  logic [7:0]  byte_sel;
  logic        fill_h;     // Upper bit fill for halves
  logic        fill_b;     // Upper bit fill for bytes
  word_t       rdata_ext;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      size_q   <= SIZE_WORD;
      ext_q    <= EXT_ZERO;
      offset_q <= 2'b00;
      we_q     <= 1'b0;
    end else if (ctrl_update_i) begin
      size_q   <= data_size_i;
      ext_q    <= ext_mode_i;
      offset_q <= addr_lsb_i;
      we_q     <= data_we_i;
    end
  end

  assign resp_w = resp_rdata_i;

  //////////////////////////////////////////////////
  // Lane selection
  always_comb begin
    case (offset_q)  // Upper lanes come from the second response
      2'd0: word_asm = resp_w;
      2'd1: word_asm = {resp_w.b[0], hold_q.b[3], hold_q.b[2], hold_q.b[1]};
      2'd2: word_asm = {resp_w.h[0], hold_q.h[1]};
      2'd3: word_asm = {resp_w.b[2], resp_w.b[1], resp_w.b[0], hold_q.b[3]};
    endcase
  end

  always_comb begin
    case (offset_q)
      2'd0: half_sel = resp_w.h[0];
      2'd1: half_sel = {resp_w.b[2], resp_w.b[1]};
      2'd2: half_sel = resp_w.h[1];
      2'd3: half_sel = {resp_w.b[0], hold_q.b[3]};  // Split half
    endcase
  end

  assign byte_sel = resp_w.b[offset_q];

  //////////////////////////////////////////////////
  // Extension
  always_comb begin
    unique case (ext_q)
      EXT_ZERO: begin
        fill_h = 1'b0;
        fill_b = 1'b0;
      end
      EXT_ONE: begin
        fill_h = 1'b1;
        fill_b = 1'b1;
      end
      EXT_SIGN, EXT_RSVD: begin
        fill_h = half_sel[15];
        fill_b = byte_sel[7];
      end
    endcase
  end

  always_comb begin
    unique case (size_q)
      SIZE_WORD:              rdata_ext = word_asm;
      SIZE_HALF:              rdata_ext = {{(`LSU_XLEN-16){fill_h}}, half_sel};
      SIZE_BYTE, SIZE_BYTE_A: rdata_ext = {{(`LSU_XLEN-8){fill_b}}, byte_sel};
    endcase
  end

  // Keeps the raw word of a first part, the final value otherwise
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hold_q <= '0;
    end else if (resp_valid_i && !we_q) begin
      if (misaligned_ex_i || misaligned_i) begin
        hold_q <= resp_w;
      end else begin
        hold_q <= rdata_ext;
      end
    end
  end

  assign rdata_ex_o = resp_valid_i ? word_t'(rdata_ext) : word_t'(hold_q);

  // Size captured at the EX to WB hand-over is known by the time its data returns
  a_resp_size_known : assert property (
    @(posedge clk) disable iff (!rst_n)
    (resp_valid_i && !we_q) |-> !$isunknown(size_q)
  );

endmodule

// ==== lsu_store_align.sv ====
// Effective address and address-phase formatting
// Byte enables, write data rotation, misaligned detection
`timescale 1ns/10ps
`include "lsu_config.svh"

module lsu_store_align (
  input  lsu_bus_pkg::addr_t         operand_a_i,      // Base register
  input  lsu_bus_pkg::addr_t         operand_b_i,      // Offset or post increment
  input  logic                       addr_useincr_i,   // Address is a + b
  input  lsu_access_pkg::data_size_e data_size_i,
  input  lsu_bus_pkg::word_t         data_wdata_i,
  input  logic [1:0]                 reg_offset_i,     // Lane of the data in the register
  input  logic                       data_req_i,
  input  logic                       misaligned_ex_i,  // Second part of a split access
  output lsu_bus_pkg::addr_t         trans_addr_o,
  output logic [1:0]                 addr_lsb_o,
  output lsu_bus_pkg::be_t           trans_be_o,
  output lsu_bus_pkg::word_t         trans_wdata_o,
  output logic                       misaligned_o      // Needs a second access
);

  import lsu_access_pkg::*;
  import lsu_bus_pkg::*;

  addr_t      eff_addr;
  logic [1:0] lsb;           // Byte offset in the word
  logic [1:0] wdata_offset;  // Rotation in bytes

  assign eff_addr   = addr_useincr_i ? (operand_a_i + operand_b_i) : operand_a_i;
  assign lsb        = eff_addr[1:0];
  assign addr_lsb_o = lsb;

  // Second part starts at lane 0 of the next word
  assign trans_addr_o = misaligned_ex_i ? {eff_addr[`LSU_XLEN-1:2], 2'b00} : eff_addr;

  //////////////////////////////////////////////////
  // Byte enables
  always_comb begin
    unique case (data_size_i)
      SIZE_WORD: begin
        if (!misaligned_ex_i) begin
          trans_be_o = 4'b1111 << lsb;          // 1111 1110 1100 1000
        end else begin
          trans_be_o = 4'b1111 >> (3'd4 - lsb);  // 0001 0011 0111 spill
        end
      end
      SIZE_HALF: begin
        if (!misaligned_ex_i) begin
          trans_be_o = 4'b0011 << lsb;  // Offset 3 keeps only lane 3
        end else begin
          trans_be_o = 4'b0001;         // Upper byte of a split half
        end
      end
      SIZE_BYTE, SIZE_BYTE_A: trans_be_o = 4'b0001 << lsb;
    endcase
  end

  //////////////////////////////////////////////////
  // Write data rotation
  assign wdata_offset = lsb - reg_offset_i;  // Wraps mod 4

  always_comb begin
    case (wdata_offset)
      2'd0: trans_wdata_o = data_wdata_i;
      2'd1: trans_wdata_o = {data_wdata_i[23:0], data_wdata_i[31:24]};
      2'd2: trans_wdata_o = {data_wdata_i[15:0], data_wdata_i[31:16]};
      2'd3: trans_wdata_o = {data_wdata_i[7:0], data_wdata_i[31:8]};
    endcase
  end

  // Word off a 4-byte boundary or half at offset 3 crosses into the next word
  always_comb begin
    misaligned_o = 1'b0;
    if (data_req_i && !misaligned_ex_i) begin
      if ((data_size_i == SIZE_WORD) && (lsb != 2'b00)) begin
        misaligned_o = 1'b1;
      end
      if ((data_size_i == SIZE_HALF) && (lsb == 2'b11)) begin
        misaligned_o = 1'b1;
      end
    end
  end

endmodule

// ==== lsu_bus_pkg.sv ====
// Bus side types of the data port
// Address, data word, byte enable, outstanding count
`include "lsu_config.svh"

package lsu_bus_pkg;

  typedef logic [`LSU_XLEN-1:0] addr_t;  // Byte address
  typedef logic [`LSU_XLEN-1:0] word_t;  // Bus data word

  // One enable per byte lane
  typedef logic [`LSU_XLEN/8-1:0] be_t;

  // Accepted transactions still waiting for rvalid
  typedef logic [`LSU_CNT_W-1:0] out_cnt_t;

endpackage

// ==== lsu_access_pkg.sv ====
// Access description types
// Data size, load extension mode and the two views of a load word
`include "lsu_config.svh"

package lsu_access_pkg;

  // Size code from the decoder
  typedef enum logic [1:0] {
    SIZE_WORD   = 2'b00,
    SIZE_HALF   = 2'b01,
    SIZE_BYTE   = 2'b10,
    SIZE_BYTE_A = 2'b11  // Second byte code
  } data_size_e;

  // Fill of the upper bits on loads
  typedef enum logic [1:0] {
    EXT_ZERO = 2'b00,
    EXT_SIGN = 2'b01,
    EXT_ONE  = 2'b10,
    EXT_RSVD = 2'b11  // Behaves as sign
  } ext_mode_e;

  // One response word picked apart by byte lane or by halfword
  typedef union packed {
    logic [`LSU_XLEN/8-1:0][7:0]   b;  // Byte lanes
    logic [`LSU_XLEN/16-1:0][15:0] h;  // Halfwords
  } load_word_u;

endpackage

// ==== lsu_config.svh ====
// Build-time sizes of the load/store unit
// Data width, outstanding depth and counter width
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// Data and address width in bits
`define LSU_XLEN 32

// Max accepted but unanswered bus transactions
`define LSU_DEPTH 2

`define LSU_CNT_W 2  // Width of the outstanding counter

`endif
